//--- run_sim.sh
#!/bin/sh
# Build and run the ROM loader simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f tb.f --top-module rom_loader_tb -o rom_loader_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/rom_loader_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
    echo "Simulation PASSED"
    exit 0
fi
echo "Simulation FAILED"
exit 1

//--- tb.f
verilog/rom_load_pkg.sv
verilog/prog_if.sv
verilog/load_regs.sv
verilog/rom_dwnld.sv
verilog/rom_scramble.sv
verilog/rom_loader.sv
testbench/rom_loader_tb.sv

//--- testbench/rom_loader_tb.sv
// ROM loader testbench driving APB and ioctl traffic from a test file and checking SDRAM and PROM writes
module rom_loader_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import rom_load_pkg::*;

    logic        clk;
    logic        reset;
    logic        psel, penable, pwrite;
    apb_addr_t   paddr;
    apb_data_t   pwdata, prdata;
    logic        pready, pslverr;
    logic        downloading, dwnld_busy;
    ioctl_addr_t ioctl_addr;
    byte_t       ioctl_dout;
    logic        ioctl_wr;
    logic        prog_we;
    prog_addr_t  prog_addr;
    byte_t       prog_data;
    lane_mask_t  prog_mask;
    logic        sdram_ack;
    logic        prom_we;
    ioctl_addr_t prom_addr;
    byte_t       prom_data;

    string            test_name[$];
    string            test_op[$];
    logic [5:0][31:0] test_field[$];  // addr, data, dl, exp1, exp2, exp3
    int               test_errors;
    int               num_tests;
    bit               tests_loaded;

    rom_loader #(.swab(1'b1)) rom_loader_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (expected == actual) else begin
            $display("Fail %s %s: expected %h, actual %h", name, field, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_true(input string name, input logic cond, input string what);
        assert (cond) else begin
            $display("Error in %s: %s", name, what);
            test_errors++;
        end
    endtask

    task automatic read_tests();
        int          fd;
        int          count;
        string       line;
        string       name;
        string       op;
        logic [31:0] a, d, dl, e1, e2, e3;
        fd = $fopen("testbench/rom_loader_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open testbench/rom_loader_tests.txt");
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line[0] == "#") continue;  // Column description
            count = $sscanf(line, "%s %s %h %h %h %h %h %h", name, op, a, d, dl, e1, e2, e3);
            if (count == 8) begin
                test_name.push_back(name);
                test_op.push_back(op);
                test_field.push_back({e3, e2, e1, dl, d, a});
            end
        end
        $fclose(fd);
        num_tests = test_name.size();
    endtask

    // Setup phase, access phase, then sample the response mid cycle
    task automatic apb_access(input logic write, input logic [31:0] addr, input logic [31:0] data,
                              input logic dl, output apb_data_t rdata, output logic err);
        @(posedge clk);
        downloading <= dl;
        psel        <= 1'b1;
        penable     <= 1'b0;
        pwrite      <= write;
        paddr       <= addr[4:0];
        pwdata      <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        check_true("apb", pready === 1'b1, "pready low in the access phase");
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic drive_byte(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk);
        while (dwnld_busy !== 1'b0) @(negedge clk);
        @(posedge clk);
        downloading <= 1'b1;
        ioctl_addr  <= addr[24:0];
        ioctl_dout  <= data[7:0];
        ioctl_wr    <= 1'b1;
        @(posedge clk);
        ioctl_wr <= 1'b0;  // Single cycle strobe
    endtask

    task automatic run_load(input string name, input logic [5:0][31:0] f);
        prog_addr_t held_addr;
        byte_t      held_data;
        lane_mask_t held_mask;
        int         waited;
        drive_byte(f[0], f[1]);
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (prog_we !== 1'b1 && waited < 12);
        check_true(name, prog_we === 1'b1, "prog_we did not rise for an SDRAM byte");
        if (prog_we === 1'b1) begin
            held_addr = prog_addr;
            held_data = prog_data;
            held_mask = prog_mask;
            check_value(name, "prog_addr", f[3], 32'(prog_addr));
            check_value(name, "prog_data", f[4], 32'(prog_data));
            check_value(name, "prog_mask", f[5], 32'(prog_mask));
            while (sdram_ack !== 1'b1) begin
                @(negedge clk);
                check_true(name, prog_we === 1'b1 && dwnld_busy === 1'b1,
                           "prog_we or dwnld_busy fell before sdram_ack");
                check_true(name, prog_addr == held_addr && prog_data == held_data &&
                           prog_mask == held_mask, "write fields changed before sdram_ack");
            end
            @(negedge clk);
            check_true(name, prog_we === 1'b0 && dwnld_busy === 1'b0,
                       "prog_we or dwnld_busy still high after sdram_ack");
        end
    endtask

    task automatic run_prom(input string name, input logic [5:0][31:0] f);
        int pulses;
        pulses = 0;
        drive_byte(f[0], f[1]);
        repeat (4) begin
            @(negedge clk);
            check_true(name, prog_we === 1'b0, "prog_we rose for a PROM byte");
            if (prom_we === 1'b1) begin
                pulses++;
                check_value(name, "prom_addr", f[3], 32'(prom_addr));
                check_value(name, "prom_data", f[4], 32'(prom_data));
            end
        end
        check_value(name, "prom_we pulses", 32'd1, 32'(pulses));
    endtask

    task automatic run_test(input int idx);
        string            name;
        logic [5:0][31:0] f;
        apb_data_t        rdata;
        logic             err;
        name        = test_name[idx];
        f           = test_field[idx];
        test_errors = 0;
        if (test_op[idx] == "apb_wr") begin
            apb_access(1'b1, f[0], f[1], f[2][0], rdata, err);
            check_value(name, "pslverr", f[3], 32'(err));
        end else if (test_op[idx] == "apb_rd") begin
            apb_access(1'b0, f[0], f[1], f[2][0], rdata, err);
            check_value(name, "prdata", f[3], rdata);
            check_value(name, "pslverr", f[4], 32'(err));
        end else if (test_op[idx] == "load") begin
            run_load(name, f);
        end else if (test_op[idx] == "prom") begin
            run_prom(name, f);
        end else begin
            check_true(name, 1'b0, "unknown operation in the test file");
        end
    endtask

    // SDRAM controller model with a random acknowledge delay
    initial begin
        int unsigned delay;
        sdram_ack = 1'b0;
        void'($urandom(32'h2ee6_1ce5));
        forever begin
            do @(negedge clk); while (prog_we !== 1'b1);
            delay = $urandom_range(7, 0);
            repeat (delay) @(posedge clk);
            @(posedge clk);
            sdram_ack <= 1'b1;
            @(posedge clk);
            sdram_ack <= 1'b0;
        end
    end

    initial begin
        wait (tests_loaded);
        repeat ((num_tests + 1) * 40) @(posedge clk);
        $display("Timeout: the tests did not finish in the allowed number of cycles");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int passed;
        int failed;
        passed      = 0;
        failed      = 0;
        reset       = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        read_tests();
        tests_loaded = 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < num_tests; i++) begin
            run_test(i);
            if (test_errors == 0) begin
                passed++;
                $display("Test %s: passed", test_name[i]);
            end else begin
                failed++;
                $display("Test %s: failed", test_name[i]);
            end
        end
        $display("Tests run: %0d, passed: %0d, failed: %0d", num_tests, passed, failed);
        if (failed == 0 && num_tests > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- testbench/rom_loader_tests.txt
# name op addr data dl exp1 exp2 exp3 (hex, unused columns 0)
# apb_wr: exp1 pslverr | apb_rd: exp1 prdata, exp2 pslverr
# load: exp1 prog_addr, exp2 prog_data, exp3 prog_mask | prom: exp1 prom_addr, exp2 prom_data
rd_scr_reset     apb_rd 00     0        0 8000  0  0
rd_obj_reset     apb_rd 04     0        0 10000 0  0
rd_pcm_reset     apb_rd 08     0        0 18000 0  0
rd_prom_reset    apb_rd 0c     0        0 20000 0  0
rd_count_reset   apb_rd 10     0        0 0     0  0
wr_pcm_start     apb_wr 08     14000    0 0     0  0
rd_pcm_start     apb_rd 08     0        0 14000 0  0
wr_unmapped      apb_wr 14     dead     0 1     0  0
rd_unmapped      apb_rd 1c     0        0 0     1  0
wr_count_ro      apb_wr 10     5        0 0     0  0
rd_count_ro      apb_rd 10     0        0 0     0  0
load_low_even    load   001234 a5       1 91a   a5 1
load_low_odd     load   001235 3c       1 91a   3c 2
load_below_scr   load   007fff 81       1 3fff  81 2
load_scr_first   load   008010 5a       1 4008  a5 1
load_scr_last    load   00ffff 12       1 7fff  21 2
load_obj_base    load   010000 77       1 8003  77 1
load_obj_odd     load   010031 c3       1 8000  c3 2
load_obj_perm    load   01006e 0f       1 803d  0f 1
load_pcm         load   014002 99       1 a001  99 1
prom_low         prom   020005 e1       1 5     e1 0
prom_high        prom   021100 4b       1 1100  4b 0
rd_count_dl      apb_rd 10     0        1 9     0  0
wr_scr_dl        apb_wr 00     1234     1 1     0  0
rd_scr_kept      apb_rd 00     0        1 8000  0  0
rd_count_end     apb_rd 10     0        0 9     0  0

//--- verilog/load_regs.sv
// APB register block with the ROM region start addresses and the SDRAM write counter
module load_regs (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  rom_load_pkg::apb_addr_t  paddr,
    input  rom_load_pkg::apb_data_t  pwdata,
    output rom_load_pkg::apb_data_t  prdata,
    output logic                     pready,
    output logic                     pslverr,
    input  logic                     downloading,
    input  logic                     write_done,
    output rom_load_pkg::prog_addr_t scr_start,
    output rom_load_pkg::prog_addr_t obj_start,
    output rom_load_pkg::prog_addr_t pcm_start,
    output rom_load_pkg::ioctl_addr_t prom_start
);
    import rom_load_pkg::*;

    apb_data_t wr_count;
    logic      downloading_d;
    logic      access;
    logic      mapped;
    logic      start_reg;
    logic      wr_ok;

    assign access    = psel && penable;
    assign start_reg = paddr == reg_scr_start || paddr == reg_obj_start ||
                       paddr == reg_pcm_start || paddr == reg_prom_start;
    assign mapped    = start_reg || paddr == reg_wr_count;

    // Region boundaries must not move under a running download
    assign pslverr = access && (!mapped || (pwrite && start_reg && downloading));
    assign pready  = 1'b1;   // Zero wait states
    assign wr_ok   = access && pwrite && !pslverr;

    always_ff @(posedge clk) begin
        if (reset) begin
            scr_start  <= scr_reset;
            obj_start  <= obj_reset;
            pcm_start  <= pcm_reset;
            prom_start <= prom_reset;
        end else if (wr_ok) begin
            case (paddr)
                reg_scr_start:  scr_start  <= pwdata[21:0];
                reg_obj_start:  obj_start  <= pwdata[21:0];
                reg_pcm_start:  pcm_start  <= pwdata[21:0];
                reg_prom_start: prom_start <= pwdata[24:0];
                default: ;  // Counter ignores writes
            endcase
        end
    end

    // Completed SDRAM writes, restarted with each download
    always_ff @(posedge clk) begin
        if (reset) begin
            downloading_d <= 1'b0;
            wr_count      <= '0;
        end else begin
            downloading_d <= downloading;
            if (downloading && !downloading_d) wr_count <= '0;
            else if (write_done)               wr_count <= wr_count + 1'b1;
        end
    end

    always_comb begin
        case (paddr)
            reg_scr_start:  prdata = apb_data_t'(scr_start);
            reg_obj_start:  prdata = apb_data_t'(obj_start);
            reg_pcm_start:  prdata = apb_data_t'(pcm_start);
            reg_prom_start: prdata = apb_data_t'(prom_start);
            reg_wr_count:   prdata = wr_count;
            default:        prdata = '0;
        endcase
    end

endmodule

//--- verilog/prog_if.sv
// One SDRAM programming write passed from the download stage to the scramble stage
interface prog_if;
    import rom_load_pkg::*;

    prog_addr_t  addr;      // Word address before scrambling
    byte_t       data;
    lane_mask_t  mask;
    ioctl_addr_t req_addr;  // Original byte address, selects the region
    logic        valid;     // One cycle per write

    modport src (
        output addr,
        output data,
        output mask,
        output req_addr,
        output valid
    );

    modport dst (
        input  addr,
        input  data,
        input  mask,
        input  req_addr,
        input  valid
    );

endinterface

//--- verilog/rom_dwnld.sv
// Download stage that turns ioctl bytes into SDRAM word writes or PROM strobes
module rom_dwnld #(
    parameter bit swab = 1'b1   // Even byte addresses on the high lane
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      downloading,
    input  rom_load_pkg::ioctl_addr_t ioctl_addr,
    input  rom_load_pkg::byte_t       ioctl_dout,
    input  logic                      ioctl_wr,
    input  rom_load_pkg::ioctl_addr_t prom_start,
    input  logic                      sdram_ack,
    output logic                      prom_we,
    output rom_load_pkg::ioctl_addr_t prom_addr,
    output rom_load_pkg::byte_t       prom_data,
    output logic                      dwnld_busy,
    prog_if.src                       prog
);
    import rom_load_pkg::*;

    dwnld_state_t state;
    logic         accept;
    logic         to_prom;
    logic         lane_hi;

    assign accept  = downloading && ioctl_wr && state == idle;
    assign to_prom = ioctl_addr >= prom_start;
    assign lane_hi = ioctl_addr[0] ^ swab;

    assign prog.valid = state == pend;
    assign dwnld_busy = state != idle;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= idle;
            prom_we <= 1'b0;
        end else begin
            prom_we <= 1'b0;
            case (state)
                idle: begin
                    if (accept) begin
                        if (to_prom) prom_we <= 1'b1;  // PROMs skip the SDRAM
                        else         state   <= pend;
                    end
                end
                pend:     state <= wait_ack;
                wait_ack: if (sdram_ack) state <= idle;
                default:  state <= idle;
            endcase
        end
    end

    // Captured byte and its word address
    always_ff @(posedge clk) begin
        if (accept) begin
            prog.addr     <= ioctl_addr[22:1];
            prog.data     <= ioctl_dout;
            prog.mask     <= lane_hi ? 2'b01 : 2'b10;
            prog.req_addr <= ioctl_addr;
            prom_addr     <= ioctl_addr - prom_start;
            prom_data     <= ioctl_dout;
        end
    end

    // Host may strobe only while idle, for a single cycle
    ioctl_rule: assert property (
        @(posedge clk) disable iff (reset)
        downloading && ioctl_wr |-> !dwnld_busy ##1 !ioctl_wr
    ) else $error("ioctl_wr while busy or held longer than one cycle");

endmodule

//--- verilog/rom_load_pkg.sv
// ROM loader shared types, APB register map and download FSM states
package rom_load_pkg;

    typedef logic [24:0] ioctl_addr_t;  // Byte address of the download stream
    typedef logic [21:0] prog_addr_t;   // SDRAM word address
    typedef logic [ 7:0] byte_t;
    typedef logic [ 1:0] lane_mask_t;   // Active low, bit 0 is the low byte
    typedef logic [ 4:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // APB register offsets
    localparam apb_addr_t reg_scr_start  = 5'h00;
    localparam apb_addr_t reg_obj_start  = 5'h04;
    localparam apb_addr_t reg_pcm_start  = 5'h08;
    localparam apb_addr_t reg_prom_start = 5'h0C;
    localparam apb_addr_t reg_wr_count   = 5'h10;  // Read only

    // Region boundaries after reset
    localparam prog_addr_t  scr_reset  = 22'h008000;
    localparam prog_addr_t  obj_reset  = 22'h010000;
    localparam prog_addr_t  pcm_reset  = 22'h018000;
    localparam ioctl_addr_t prom_reset = 25'h0020000;

    // Download FSM
    // idle waits for a byte, pend presents it downstream for one cycle,
    // wait_ack holds until the SDRAM controller takes it
    typedef enum logic [1:0] {
        idle,
        pend,
        wait_ack
    } dwnld_state_t;

endpackage

//--- verilog/rom_loader.sv
// ROM loading path top level with the APB register block, download and scramble stages
module rom_loader #(
    parameter bit swab = 1'b1
) (
    input  logic                      clk,
    input  logic                      reset,
    // APB register access
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  rom_load_pkg::apb_addr_t   paddr,
    input  rom_load_pkg::apb_data_t   pwdata,
    output rom_load_pkg::apb_data_t   prdata,
    output logic                      pready,
    output logic                      pslverr,
    // ROM download stream
    input  logic                      downloading,
    output logic                      dwnld_busy,
    input  rom_load_pkg::ioctl_addr_t ioctl_addr,
    input  rom_load_pkg::byte_t       ioctl_dout,
    input  logic                      ioctl_wr,
    // SDRAM programming
    output logic                      prog_we,
    output rom_load_pkg::prog_addr_t  prog_addr,
    output rom_load_pkg::byte_t       prog_data,
    output rom_load_pkg::lane_mask_t  prog_mask,
    input  logic                      sdram_ack,
    // PROM programming
    output logic                      prom_we,
    output rom_load_pkg::ioctl_addr_t prom_addr,
    output rom_load_pkg::byte_t       prom_data
);
    import rom_load_pkg::*;

    prog_addr_t  scr_start, obj_start, pcm_start;
    ioctl_addr_t prom_start;
    logic        write_done;

    prog_if prog ();

    load_regs u_regs (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .psel        ( psel        ),
        .penable     ( penable     ),
        .pwrite      ( pwrite      ),
        .paddr       ( paddr       ),
        .pwdata      ( pwdata      ),
        .prdata      ( prdata      ),
        .pready      ( pready      ),
        .pslverr     ( pslverr     ),
        .downloading ( downloading ),
        .write_done  ( write_done  ),
        .scr_start   ( scr_start   ),
        .obj_start   ( obj_start   ),
        .pcm_start   ( pcm_start   ),
        .prom_start  ( prom_start  )
    );

    rom_dwnld #(.swab(swab)) u_dwnld (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .prom_start  ( prom_start  ),
        .sdram_ack   ( sdram_ack   ),
        .prom_we     ( prom_we     ),
        .prom_addr   ( prom_addr   ),
        .prom_data   ( prom_data   ),
        .dwnld_busy  ( dwnld_busy  ),
        .prog        ( prog.src    )
    );

    rom_scramble u_scramble (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .sdram_ack   ( sdram_ack   ),
        .scr_start   ( scr_start   ),
        .obj_start   ( obj_start   ),
        .pcm_start   ( pcm_start   ),
        .prog        ( prog.dst    ),
        .prog_we     ( prog_we     ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .write_done  ( write_done  )
    );

endmodule

//--- verilog/rom_scramble.sv
// Scramble stage that rearranges tile ROM bytes and holds each SDRAM write until acknowledged
module rom_scramble (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     sdram_ack,
    input  rom_load_pkg::prog_addr_t scr_start,
    input  rom_load_pkg::prog_addr_t obj_start,
    input  rom_load_pkg::prog_addr_t pcm_start,
    prog_if.dst                      prog,
    output logic                     prog_we,
    output rom_load_pkg::prog_addr_t prog_addr,
    output rom_load_pkg::byte_t      prog_data,
    output rom_load_pkg::lane_mask_t prog_mask,
    output logic                     write_done
);
    import rom_load_pkg::*;

    dwnld_state_t out_state;  // Only idle and wait_ack are used here
    prog_addr_t   region_addr;
    prog_addr_t   next_addr;
    byte_t        next_data;
    logic         in_scr;
    logic         in_obj;

    assign region_addr = prog.req_addr[21:0];
    assign in_scr = region_addr >= scr_start && region_addr < obj_start;
    assign in_obj = region_addr >= obj_start && region_addr < pcm_start;

    always_comb begin
        next_addr = prog.addr;
        next_data = prog.data;
        if (in_scr) next_data = {prog.data[3:0], prog.data[7:4]};  // Nibble swap
        if (in_obj) begin
            // Object tiles use a shuffled, partly inverted word order
            next_addr[0]   = ~prog.addr[3];
            next_addr[1]   = ~prog.addr[4];
            next_addr[5:2] = {prog.addr[5], prog.addr[2:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset)                                      out_state <= idle;
        else if (prog.valid)                            out_state <= wait_ack;
        else if (out_state == wait_ack && sdram_ack)    out_state <= idle;
    end

    always_ff @(posedge clk) begin
        if (prog.valid) begin
            prog_addr <= next_addr;
            prog_data <= next_data;
            prog_mask <= prog.mask;
        end
    end

    assign prog_we    = out_state == wait_ack;
    assign write_done = prog_we && sdram_ack;

    // Request stays put until the controller takes it
    hold_stable: assert property (
        @(posedge clk) disable iff (reset)
        prog_we && !sdram_ack |=> prog_we && $stable(prog_addr) &&
                                  $stable(prog_data) && $stable(prog_mask)
    ) else $error("prog write changed before sdram_ack");

    // Download stage never overruns a pending write
    no_overrun: assert property (
        @(posedge clk) disable iff (reset)
        prog.valid |-> out_state != wait_ack
    ) else $error("new write while prog_we still pending");

endmodule
